// File: logic/cpc_glue_pkg.sv
// CPC glue shared definitions
// Widths, bus structs and enums used by the ROM loader,
// the Multiface Two blocks and the testbench

package cpc_glue_pkg;

	//////////////////////////////////////////////////
	// Widths
	//////////////////////////////////////////////////

	localparam int ROM_PAGE_W = 8;   // 16 KB page index in upper ROM space
	localparam int MEM_AW     = 23;  // Memory write address
	localparam int IO_ADDR_W  = 25;  // Download address

	//////////////////////////////////////////////////
	// Bus structs
	//////////////////////////////////////////////////

	// Download port from the file loader
	typedef struct packed {
		logic                 wr;        // Byte strobe
		logic [IO_ADDR_W-1:0] addr;
		logic [7:0]           data;
		logic                 download;  // High for the whole transfer
		logic [7:0]           index;     // 0 ROM set, 3 expansion
		logic [15:0]          file_ext;  // Two ASCII chars, first in top byte
	} ioctl_t;

	// Memory write during boot load
	typedef struct packed {
		logic              wr;
		logic [MEM_AW-1:0] addr;
		logic [1:0]        bank;
		logic [7:0]        data;
	} boot_wr_t;

	// Z80 side of the motherboard
	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  dout;    // CPU write data
		logic        m1;      // Opcode fetch
		logic        io_wr;
		logic        mem_rd;
		logic        mem_wr;
	} cpu_bus_t;

	//////////////////////////////////////////////////
	// Enums
	//////////////////////////////////////////////////

	// Multiface option
	typedef enum logic [1:0] {
		MF2_ENABLED  = 2'd0,
		MF2_HIDDEN   = 2'd1,
		MF2_DISABLED = 2'd2
	} mf2_mode_t;

	// Hardware register kind caught by the shadow RAM
	typedef enum logic [3:0] {
		SH_NONE        = 4'd0,
		SH_PEN_INDEX   = 4'd1,
		SH_PEN_COLOR   = 4'd2,
		SH_SCREEN_MODE = 4'd3,
		SH_BANKING     = 4'd4,
		SH_CRTC_SELECT = 4'd5,
		SH_CRTC_VALUE  = 4'd6,
		SH_PPI         = 4'd7,
		SH_UPPER_ROM   = 4'd8
	} shadow_reg_t;

	typedef enum logic [1:0] {
		DL_NONE = 2'd0,
		DL_ROM  = 2'd1,  // index 0
		DL_EXT  = 2'd2   // index 3
	} download_kind_t;

endpackage

// File: logic/rom_loader.sv
// ROM and expansion loader
// Maps download bytes to boot memory writes, decodes the expansion page
// from the file extension and keeps the map of loaded upper ROM pages

`timescale 1ns/100ps

module rom_loader (
	input  logic                              clk_sys,
	input  logic                              reset,
	input  cpc_glue_pkg::ioctl_t              ioctl,
	input  logic                              model,     // 0 = 6128, 1 = 664
	input  cpc_glue_pkg::mf2_mode_t           mf2_mode,
	input  logic [cpc_glue_pkg::MEM_AW-1:0]   mem_addr,
	output cpc_glue_pkg::boot_wr_t            boot,
	output logic                              loading,
	output logic                              rom_mask
);

	localparam int PW = cpc_glue_pkg::ROM_PAGE_W;

	cpc_glue_pkg::download_kind_t kind;

	logic [PW:0]      page;       // Bit 8 selects upper ROM space
	logic             combo;      // Z0 file, last block goes to the MF2 page
	logic [PW:0]      ext_page;
	logic             ext_combo;
	logic [4:0]       hi_nib;
	logic [4:0]       lo_nib;
	logic             old_wr;
	logic             old_download;
	logic             wr_fall;
	logic             dl_rise;
	logic [2**PW-1:0] rom_map = '0;  // One bit per 16 KB upper page
	logic [PW-1:0]    map_addr;

	// Hex digit to {valid, nibble}
	function automatic logic [4:0] hex_nibble(input logic [7:0] c);
		logic [4:0] r;
		r = 5'd0;
		if (c >= "0" && c <= "9")
			r = {1'b1, c[3:0]};
		else if (c >= "A" && c <= "F")
			r = {1'b1, c[3:0] + 4'd9};
		return r;
	endfunction

	always_comb begin
		kind = cpc_glue_pkg::DL_NONE;
		if (ioctl.download && ioctl.index == 8'd0)
			kind = cpc_glue_pkg::DL_ROM;
		else if (ioctl.download && ioctl.index == 8'd3)
			kind = cpc_glue_pkg::DL_EXT;
	end

	assign loading = (kind != cpc_glue_pkg::DL_NONE);
	assign wr_fall = loading & old_wr & ~ioctl.wr;
	assign dl_rise = ~old_download & ioctl.download;

	//////////////////////////////////////////////////
	// Extension decode
	//////////////////////////////////////////////////

	always_comb begin
		hi_nib    = hex_nibble(ioctl.file_ext[15:8]);
		lo_nib    = hex_nibble(ioctl.file_ext[7:0]);
		ext_combo = 1'b0;
		if (ioctl.file_ext == "ZZ") begin
			ext_page = '0;
		end else if (ioctl.file_ext == "Z0") begin
			ext_page  = '0;
			ext_combo = 1'b1;
		end else if (hi_nib[4] && lo_nib[4]) begin
			ext_page = {1'b0, hi_nib[3:0], lo_nib[3:0]};
		end else begin
			ext_page = 9'h1EE;  // Unused page for bad extensions
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			old_wr       <= 1'b0;
			old_download <= 1'b0;
			page         <= '0;
			combo        <= 1'b0;
		end else begin
			old_wr       <= ioctl.wr;
			old_download <= ioctl.download;
			if (wr_fall && combo && &boot.addr[13:0]) begin
				combo <= 1'b0;
				page  <= 9'h1FF;  // Rest of the file is the MF2 ROM
			end
			if (dl_rise && kind == cpc_glue_pkg::DL_EXT) begin
				page  <= ext_page;
				combo <= ext_combo;
			end
		end
	end

	//////////////////////////////////////////////////
	// Boot address mapping
	//////////////////////////////////////////////////

	always_comb begin
		boot.wr          = loading & ioctl.wr;
		boot.data        = ioctl.data;
		boot.addr[13:0]  = ioctl.addr[13:0];
		boot.addr[22:14] = '1;
		boot.bank        = 2'd0;
		if (kind == cpc_glue_pkg::DL_EXT) begin
			boot.addr[22]    = page[PW];
			boot.addr[21:14] = page[PW-1:0] + ioctl.addr[21:14];
			boot.bank        = {1'b0, model};
		end else begin
			case (ioctl.addr[24:14])
				11'd0, 11'd4: boot.addr[22:14] = 9'h000;  // OS
				11'd1, 11'd5: boot.addr[22:14] = 9'h100;  // BASIC
				11'd2, 11'd6: boot.addr[22:14] = 9'h107;  // AMSDOS
				11'd3, 11'd7: boot.addr[22:14] = 9'h1FF;  // MF2
				default:      boot.wr = 1'b0;
			endcase
			if (ioctl.addr[24:14] >= 11'd4 && ioctl.addr[24:14] <= 11'd7)
				boot.bank = 2'd1;  // 664 set
		end
	end

	// Loaded pages survive reset
	always_ff @(posedge clk_sys) begin
		if (wr_fall && boot.addr[22])
			rom_map[boot.addr[21:14]] <= 1'b1;
	end

	assign map_addr = mem_addr[21:14];
	assign rom_mask = mem_addr[22] & (~rom_map[map_addr] |
		(&map_addr & (mf2_mode == cpc_glue_pkg::MF2_DISABLED)));

endmodule

// File: logic/mf2_control.sv
// Multiface Two control
// NMI button trap, enable and hidden state, FEE8/FEEA ports
// and the ROM and RAM window decode

`timescale 1ns/100ps

module mf2_control #(
	parameter int MF2_RAM_AW = 13
) (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  cpc_glue_pkg::mf2_mode_t mf2_mode,
	input  cpc_glue_pkg::cpu_bus_t  cpu,
	input  logic                    key_nmi,
	output logic                    nmi,
	output logic                    mf2_active,
	output logic                    mf2_rom_en,
	output logic                    mf2_ram_en
);

	localparam int WIN_W = 16 - MF2_RAM_AW;

	logic             old_key_nmi;
	logic             old_m1;
	logic             old_io_wr;
	logic             hidden;      // Ports cannot re-enable the MF2
	logic             key_rise;
	logic             m1_rise;
	logic             io_rise;
	logic             ctrl_port;
	logic [WIN_W-1:0] win;

	assign key_rise  = ~old_key_nmi & key_nmi;
	assign m1_rise   = ~old_m1 & cpu.m1;
	assign io_rise   = ~old_io_wr & cpu.io_wr;
	assign ctrl_port = (cpu.addr[15:2] == 14'b1111_1110_1110_10);  // FEE8 or FEEA

	//////////////////////////////////////////////////
	// NMI trap and enable state
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			old_key_nmi <= 1'b0;
			old_m1      <= 1'b0;
			old_io_wr   <= 1'b0;
			nmi         <= 1'b0;
			mf2_active  <= 1'b0;
			hidden      <= (mf2_mode != cpc_glue_pkg::MF2_ENABLED);
		end else begin
			old_key_nmi <= key_nmi;
			old_m1      <= cpu.m1;
			old_io_wr   <= cpu.io_wr;

			if (key_rise && !mf2_active && mf2_mode != cpc_glue_pkg::MF2_DISABLED)
				nmi <= 1'b1;

			// CPU enters the NMI handler
			if (nmi && m1_rise && cpu.addr == 16'h0066) begin
				mf2_active <= 1'b1;
				hidden     <= 1'b0;
				nmi        <= 1'b0;
			end
			if (mf2_active && m1_rise && cpu.addr == 16'h0065)
				hidden <= 1'b1;

			if (io_rise && ctrl_port)
				mf2_active <= ~cpu.addr[1] & ~hidden;  // FEE8 on, FEEA off
		end
	end

	// ROM at 0000, RAM at 2000
	assign win        = cpu.addr[15:MF2_RAM_AW];
	assign mf2_rom_en = mf2_active & (win == WIN_W'(0));
	assign mf2_ram_en = mf2_active & (win == WIN_W'(1));

endmodule

// File: logic/mf2_shadow.sv
// Multiface Two shadow RAM
// Records writes to the gate array, CRTC, 8255 and upper ROM ports
// and serves the 0x2000 RAM window with a registered read path

`timescale 1ns/100ps

module mf2_shadow #(
	parameter int MF2_RAM_AW = 13
) (
	input  logic                   clk_sys,
	input  cpc_glue_pkg::cpu_bus_t cpu,
	input  logic                   mf2_ram_en,
	output logic [7:0]             mf2_dout
);

	cpc_glue_pkg::shadow_reg_t kind;

	logic [12:0]           store_addr;
	logic [4:0]            pen_index;     // Bit 4 selects the border
	logic [3:0]            crtc_reg;
	logic                  old_io_wr;
	logic                  io_rise;
	logic [MF2_RAM_AW-1:0] ram_a;
	logic                  ram_we;
	logic [7:0]            ram_in;
	logic [7:0]            ram_out;
	logic [7:0]            ram [0:2**MF2_RAM_AW-1];

	assign io_rise = ~old_io_wr & cpu.io_wr;

	//////////////////////////////////////////////////
	// Port decode
	//////////////////////////////////////////////////

	always_comb begin
		case (cpu.addr[15:8])
			8'h7F: begin  // Gate array, function in the top two data bits
				case (cpu.dout[7:6])
					2'b00:   kind = cpc_glue_pkg::SH_PEN_INDEX;
					2'b01:   kind = cpc_glue_pkg::SH_PEN_COLOR;
					2'b10:   kind = cpc_glue_pkg::SH_SCREEN_MODE;
					default: kind = cpc_glue_pkg::SH_BANKING;
				endcase
			end
			8'hBC:   kind = cpc_glue_pkg::SH_CRTC_SELECT;
			8'hBD:   kind = cpc_glue_pkg::SH_CRTC_VALUE;
			8'hF7:   kind = cpc_glue_pkg::SH_PPI;         // 8255 control
			8'hDF:   kind = cpc_glue_pkg::SH_UPPER_ROM;
			default: kind = cpc_glue_pkg::SH_NONE;
		endcase
	end

	always_comb begin
		case (kind)
			cpc_glue_pkg::SH_PEN_INDEX:   store_addr = 13'h1FCF;
			cpc_glue_pkg::SH_PEN_COLOR:
				store_addr = pen_index[4] ? 13'h1FDF : {9'h1F9, pen_index[3:0]};
			cpc_glue_pkg::SH_SCREEN_MODE: store_addr = 13'h1FEF;
			cpc_glue_pkg::SH_BANKING:     store_addr = 13'h1FFF;
			cpc_glue_pkg::SH_CRTC_SELECT: store_addr = 13'h1CFF;
			cpc_glue_pkg::SH_CRTC_VALUE:  store_addr = {9'h1DB, crtc_reg};
			cpc_glue_pkg::SH_PPI:         store_addr = 13'h17FF;
			cpc_glue_pkg::SH_UPPER_ROM:   store_addr = 13'h1AAC;
			default:                      store_addr = 13'h0000;
		endcase
	end

	// First stage, address and data register
	always_ff @(posedge clk_sys) begin
		old_io_wr <= cpu.io_wr;
		if (io_rise && kind != cpc_glue_pkg::SH_NONE) begin
			if (kind == cpc_glue_pkg::SH_PEN_INDEX)
				pen_index <= cpu.dout[4:0];
			if (kind == cpc_glue_pkg::SH_CRTC_SELECT)
				crtc_reg <= cpu.dout[3:0];
			ram_a  <= MF2_RAM_AW'(store_addr);
			ram_in <= cpu.dout;
			ram_we <= 1'b1;
		end else if (cpu.mem_wr && mf2_ram_en) begin
			ram_a  <= cpu.addr[MF2_RAM_AW-1:0];  // Normal window write
			ram_in <= cpu.dout;
			ram_we <= 1'b1;
		end else begin
			ram_a  <= cpu.addr[MF2_RAM_AW-1:0];
			ram_we <= 1'b0;
		end
	end

	// Second stage, RAM array with write-through output
	always_ff @(posedge clk_sys) begin
		if (ram_we) begin
			ram[ram_a] <= ram_in;
			ram_out    <= ram_in;
		end else begin
			ram_out <= ram[ram_a];
		end
	end

	// Idle bus reads as FF for the wired-AND data bus
	assign mf2_dout = (mf2_ram_en & cpu.mem_rd) ? ram_out : 8'hFF;

endmodule

// File: logic/cpc_glue.sv
// CPC 6128 support logic top level
// ROM and expansion loader beside the Multiface Two control
// and shadow RAM

`timescale 1ns/100ps

module cpc_glue #(
	parameter int MF2_RAM_AW = 13  // 8 KB shadow RAM
) (
	input  logic                            clk_sys,
	input  logic                            reset,
	input  cpc_glue_pkg::ioctl_t            ioctl,
	input  logic                            model,
	input  cpc_glue_pkg::mf2_mode_t         mf2_mode,
	input  cpc_glue_pkg::cpu_bus_t          cpu,
	input  logic [cpc_glue_pkg::MEM_AW-1:0] mem_addr,
	input  logic                            key_nmi,
	output cpc_glue_pkg::boot_wr_t          boot,
	output logic                            loading,
	output logic                            rom_mask,
	output logic                            nmi,
	output logic                            mf2_active,
	output logic                            mf2_rom_en,
	output logic                            mf2_ram_en,
	output logic [7:0]                      mf2_dout
);

	//////////////////////////////////////////////////
	// ROM loader
	rom_loader u_rom_loader (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.ioctl    (ioctl),
		.model    (model),
		.mf2_mode (mf2_mode),
		.mem_addr (mem_addr),
		.boot     (boot),
		.loading  (loading),
		.rom_mask (rom_mask)
	);

	//////////////////////////////////////////////////
	// Multiface Two
	mf2_control #(.MF2_RAM_AW(MF2_RAM_AW)) u_mf2_control (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.mf2_mode   (mf2_mode),
		.cpu        (cpu),
		.key_nmi    (key_nmi),
		.nmi        (nmi),
		.mf2_active (mf2_active),
		.mf2_rom_en (mf2_rom_en),
		.mf2_ram_en (mf2_ram_en)
	);

	mf2_shadow #(.MF2_RAM_AW(MF2_RAM_AW)) u_mf2_shadow (
		.clk_sys    (clk_sys),
		.cpu        (cpu),
		.mf2_ram_en (mf2_ram_en),  // Window decode from the control block
		.mf2_dout   (mf2_dout)
	);

endmodule

// File: verification/cpc_glue_checker.sv
// Multiface Two control checker
// Concurrent assertions on the NMI and the active state

`timescale 1ns/100ps

module mf2_control_checker (
	input logic                    clk_sys,
	input logic                    reset,
	input logic                    nmi,
	input logic                    mf2_active,
	input logic                    hidden,
	input cpc_glue_pkg::mf2_mode_t mf2_mode
);

	// NMI is cleared on the same clock that the MF2 turns active
	a_nmi_active_excl: assert property (@(posedge clk_sys) disable iff (reset)
		!(nmi && mf2_active))
		else $error("nmi and mf2_active are high together");

	// Only an NMI entry, or a port write while visible, turns the MF2 on
	a_active_source: assert property (@(posedge clk_sys) disable iff (reset)
		$rose(mf2_active) |-> $past(nmi) || !$past(hidden))
		else $error("mf2_active rose without an NMI entry or a visible port write");

	a_nmi_disabled: assert property (@(posedge clk_sys) disable iff (reset)
		$rose(nmi) |-> $past(mf2_mode) != cpc_glue_pkg::MF2_DISABLED)
		else $error("nmi rose while the Multiface is disabled");

endmodule

bind mf2_control mf2_control_checker u_checker (
	.clk_sys    (clk_sys),
	.reset      (reset),
	.nmi        (nmi),
	.mf2_active (mf2_active),
	.hidden     (hidden),
	.mf2_mode   (mf2_mode)
);

// File: verification/cpc_glue_tb.sv
// CPC glue testbench
// ROM download mapping, expansion pages, ROM mask, NMI trap and shadow RAM

`timescale 1ns/100ps

module cpc_glue_tb;

	localparam int CLK_PERIOD   = 8;
	localparam int RESET_CYCLES = 16;
	localparam int TEST_CYCLES  = 60 + 60 + 560 + 40 + 80;  // Budget per test, summed
	localparam int LIMIT_CYCLES = 2 * (RESET_CYCLES + TEST_CYCLES);

	typedef struct packed {
		cpc_glue_pkg::shadow_reg_t kind;
		logic [12:0]               addr;
	} shadow_ref_t;

	logic                    clk_sys = 1'b0;
	logic                    reset;
	cpc_glue_pkg::ioctl_t    ioctl;
	logic                    model;
	cpc_glue_pkg::mf2_mode_t mf2_mode;
	cpc_glue_pkg::cpu_bus_t  cpu;
	logic [22:0]             mem_addr;
	logic                    key_nmi;
	cpc_glue_pkg::boot_wr_t  boot;
	logic                    loading;
	logic                    rom_mask;
	logic                    nmi;
	logic                    mf2_active;
	logic                    mf2_rom_en;
	logic                    mf2_ram_en;
	logic [7:0]              mf2_dout;

	integer      seed   = 59889;
	int          errors = 0;
	int          checks = 0;
	int          tests  = 0;
	logic [8:0]  ref_page  = 9'h000;  // Expected expansion page register
	logic        ref_combo = 1'b0;
	logic        ref_map [0:255];
	logic [7:0]  ref_ram [0:8191];
	logic [4:0]  ref_pen  = 5'd0;
	logic [3:0]  ref_crtc = 4'd0;
	logic [12:0] stored [$];

	cpc_glue u_dut (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.ioctl      (ioctl),
		.model      (model),
		.mf2_mode   (mf2_mode),
		.cpu        (cpu),
		.mem_addr   (mem_addr),
		.key_nmi    (key_nmi),
		.boot       (boot),
		.loading    (loading),
		.rom_mask   (rom_mask),
		.nmi        (nmi),
		.mf2_active (mf2_active),
		.mf2_rom_en (mf2_rom_en),
		.mf2_ram_en (mf2_ram_en),
		.mf2_dout   (mf2_dout)
	);

	always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

	//////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////

	function automatic int hex_value(input logic [7:0] c);
		if (c >= "0" && c <= "9")
			return int'(c) - 48;
		if (c >= "A" && c <= "F")
			return int'(c) - 55;
		return -1;
	endfunction

	function automatic logic [8:0] ref_ext_page(input logic [15:0] ext);
		int hi;
		int lo;
		hi = hex_value(ext[15:8]);
		lo = hex_value(ext[7:0]);
		if (ext == "ZZ" || ext == "Z0")
			return 9'h000;
		if (hi < 0 || lo < 0)
			return 9'h1EE;  // Malformed extension
		return 9'(hi * 16 + lo);
	endfunction

	function automatic cpc_glue_pkg::boot_wr_t ref_boot_wr(input cpc_glue_pkg::ioctl_t io,
		input logic mdl, input logic [8:0] pg);
		cpc_glue_pkg::boot_wr_t b;
		logic [10:0] blk;
		logic [8:0]  base;
		blk    = io.addr[24:14];
		b.wr   = io.wr;
		b.data = io.data;
		b.bank = 2'd0;
		base   = 9'h000;
		if (io.index == 8'd3) begin
			base   = pg + {1'b0, blk[7:0]};
			b.bank = {1'b0, mdl};
		end else if (blk >= 11'd8) begin
			b.wr = 1'b0;  // Beyond the eight ROM blocks
		end else begin
			case (blk[1:0])
				2'd0: base = 9'h000;
				2'd1: base = 9'h100;
				2'd2: base = 9'h107;
				default: base = 9'h1FF;
			endcase
			b.bank = {1'b0, blk[2]};
		end
		b.addr = {base, io.addr[13:0]};
		return b;
	endfunction

	function automatic shadow_ref_t ref_shadow_addr(input logic [15:0] port,
		input logic [7:0] data, input logic [4:0] pen, input logic [3:0] crtc);
		shadow_ref_t r;
		r.kind = cpc_glue_pkg::SH_NONE;
		r.addr = 13'h0000;
		if (port[15:8] == 8'h7F) begin
			if (data[7:6] == 2'b00) begin
				r.kind = cpc_glue_pkg::SH_PEN_INDEX;
				r.addr = 13'h1FCF;
			end else if (data[7:6] == 2'b01) begin
				r.kind = cpc_glue_pkg::SH_PEN_COLOR;
				r.addr = pen[4] ? 13'h1FDF : 13'h1F90 + {9'h000, pen[3:0]};
			end else if (data[7:6] == 2'b10) begin
				r.kind = cpc_glue_pkg::SH_SCREEN_MODE;
				r.addr = 13'h1FEF;
			end else begin
				r.kind = cpc_glue_pkg::SH_BANKING;
				r.addr = 13'h1FFF;
			end
		end else if (port[15:8] == 8'hBC) begin
			r.kind = cpc_glue_pkg::SH_CRTC_SELECT;
			r.addr = 13'h1CFF;
		end else if (port[15:8] == 8'hBD) begin
			r.kind = cpc_glue_pkg::SH_CRTC_VALUE;
			r.addr = 13'h1DB0 + {9'h000, crtc};
		end else if (port[15:8] == 8'hF7) begin
			r.kind = cpc_glue_pkg::SH_PPI;
			r.addr = 13'h17FF;
		end else if (port[15:8] == 8'hDF) begin
			r.kind = cpc_glue_pkg::SH_UPPER_ROM;
			r.addr = 13'h1AAC;
		end
		return r;
	endfunction

	//////////////////////////////////////////////////
	// Compare tasks
	//////////////////////////////////////////////////

	task automatic check_boot(input string name, input cpc_glue_pkg::boot_wr_t got,
		input cpc_glue_pkg::boot_wr_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail %0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail %0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail %0t %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	task automatic finish_test(input string name, input int errs_before);
		tests++;
		if (errors == errs_before)
			$display("Test %0d %s ok", tests, name);
		else
			$display("Test %0d %s saw %0d errors", tests, name, errors - errs_before);
	endtask

	//////////////////////////////////////////////////
	// Stimulus helpers
	//////////////////////////////////////////////////

	task automatic start_download(input logic [7:0] index, input logic [15:0] ext);
		@(negedge clk_sys);
		ioctl.index    = index;
		ioctl.file_ext = ext;
		ioctl.download = 1'b1;
		repeat (2) @(negedge clk_sys);  // Page register loads after the edge
		check_bit("loading", loading, 1'b1);
		if (index == 8'd3) begin
			ref_page  = ref_ext_page(ext);
			ref_combo = (ext == "Z0");
		end
	endtask

	task automatic end_download;
		@(negedge clk_sys);
		ioctl.download = 1'b0;
		@(negedge clk_sys);
		check_bit("loading", loading, 1'b0);
	endtask

	task automatic write_byte(input logic [24:0] addr, input logic [7:0] data);
		cpc_glue_pkg::boot_wr_t exp;
		@(negedge clk_sys);
		ioctl.addr = addr;
		ioctl.data = data;
		ioctl.wr   = 1'b1;
		#1;
		exp = ref_boot_wr(ioctl, model, ref_page);
		if (exp.wr)
			check_boot("boot", boot, exp);
		else
			check_bit("boot.wr", boot.wr, 1'b0);
		@(negedge clk_sys);
		ioctl.wr = 1'b0;
		@(negedge clk_sys);  // Falling strobe updates map and page
		if (exp.wr && exp.addr[22])
			ref_map[exp.addr[21:14]] = 1'b1;
		if (ref_combo && &addr[13:0]) begin
			ref_page  = 9'h1FF;
			ref_combo = 1'b0;
		end
	endtask

	task automatic check_mask_all;
		logic exp;
		for (int p = 0; p < 256; p++) begin
			@(negedge clk_sys);
			mem_addr = {1'b1, 8'(p), 14'h0123};
			#1;
			exp = ~ref_map[p] | (p == 255 && mf2_mode == cpc_glue_pkg::MF2_DISABLED);
			check_bit("rom_mask", rom_mask, exp);
		end
		@(negedge clk_sys);
		mem_addr = 23'h00_4000;  // Lower space is never masked
		#1;
		check_bit("rom_mask", rom_mask, 1'b0);
		@(negedge clk_sys);
	endtask

	task automatic trap_nmi;
		@(negedge clk_sys);
		key_nmi = 1'b1;
		@(negedge clk_sys);
		check_bit("nmi", nmi, 1'b1);
		key_nmi = 1'b0;
		cpu.addr = 16'h0066;
		cpu.m1   = 1'b1;
		@(negedge clk_sys);
		check_bit("nmi", nmi, 1'b0);
		check_bit("mf2_active", mf2_active, 1'b1);
		cpu.m1 = 1'b0;
	endtask

	task automatic check_windows(input logic [15:0] addr, input logic rom_exp,
		input logic ram_exp);
		@(negedge clk_sys);
		cpu.addr = addr;
		#1;
		check_bit("mf2_rom_en", mf2_rom_en, rom_exp);
		check_bit("mf2_ram_en", mf2_ram_en, ram_exp);
	endtask

	task automatic io_write(input logic [15:0] port, input logic [7:0] data);
		shadow_ref_t exp;
		exp = ref_shadow_addr(port, data, ref_pen, ref_crtc);
		@(negedge clk_sys);
		cpu.addr  = port;
		cpu.dout  = data;
		cpu.io_wr = 1'b1;
		@(negedge clk_sys);
		cpu.io_wr = 1'b0;
		@(negedge clk_sys);  // RAM write lands on this clock
		if (exp.kind == cpc_glue_pkg::SH_PEN_INDEX)
			ref_pen = data[4:0];
		if (exp.kind == cpc_glue_pkg::SH_CRTC_SELECT)
			ref_crtc = data[3:0];
		if (exp.kind != cpc_glue_pkg::SH_NONE) begin
			ref_ram[exp.addr] = data;
			stored.push_back(exp.addr);
		end
	endtask

	task automatic read_window(input logic [15:0] addr, input logic [7:0] exp);
		@(negedge clk_sys);
		cpu.addr   = addr;
		cpu.mem_rd = 1'b1;
		repeat (2) @(negedge clk_sys);  // Address register, then RAM output
		check_byte("mf2_dout", mf2_dout, exp);
		cpu.mem_rd = 1'b0;
	endtask

	//////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////

	initial begin
		int          e;
		logic [15:0] exts [4];
		reset    = 1'b1;
		ioctl    = '0;
		model    = 1'b0;
		mf2_mode = cpc_glue_pkg::MF2_ENABLED;
		cpu      = '0;
		mem_addr = '0;
		key_nmi  = 1'b0;
		exts     = '{"1A", "F3", "ZZ", "Q7"};
		for (int i = 0; i < 256; i++)
			ref_map[i] = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk_sys);
		@(negedge clk_sys);
		reset = 1'b0;

		e = errors;
		start_download(8'd0, "RM");
		for (int b = 0; b < 10; b++)
			write_byte({11'(b), 14'($random(seed))}, 8'($random(seed)));
		end_download();
		finish_test("ROM download mapping", e);

		e = errors;
		for (int i = 0; i < 4; i++) begin
			model = i[0];
			start_download(8'd3, exts[i]);
			write_byte({9'h000, 2'($random(seed)), 14'($random(seed))}, 8'($random(seed)));
			end_download();
		end
		model = 1'b0;
		finish_test("expansion page decode", e);

		e = errors;
		start_download(8'd3, "Z0");
		write_byte(25'h000_3FFF, 8'($random(seed)));  // Last byte of the combo block
		write_byte(25'h000_0010, 8'($random(seed)));
		end_download();
		check_mask_all();
		mf2_mode = cpc_glue_pkg::MF2_DISABLED;
		check_mask_all();
		mf2_mode = cpc_glue_pkg::MF2_ENABLED;
		finish_test("ROM map and mask", e);

		e = errors;
		trap_nmi();
		check_windows(16'h0100, 1'b1, 1'b0);
		check_windows(16'h2100, 1'b0, 1'b1);
		check_windows(16'h4000, 1'b0, 1'b0);
		io_write(16'hFEEA, 8'h00);
		check_bit("mf2_active", mf2_active, 1'b0);
		@(negedge clk_sys);
		mf2_mode = cpc_glue_pkg::MF2_DISABLED;
		key_nmi  = 1'b1;
		repeat (2) @(negedge clk_sys);
		check_bit("nmi", nmi, 1'b0);
		key_nmi  = 1'b0;
		mf2_mode = cpc_glue_pkg::MF2_ENABLED;
		finish_test("NMI trap", e);

		e = errors;
		trap_nmi();
		io_write(16'h7F00, 8'h03);
		io_write(16'h7F45, {2'b01, 6'($random(seed))});
		io_write(16'hBC07, {4'h0, 4'($random(seed))});
		io_write(16'hBD12, 8'($random(seed)));
		io_write(16'hF700, 8'($random(seed)));
		foreach (stored[i])
			read_window(16'h2000 | {3'b000, stored[i]}, ref_ram[stored[i]]);
		read_window(16'h4000, 8'hFF);
		finish_test("shadow store and read", e);

		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

	// Watchdog
	initial begin
		#(LIMIT_CYCLES * CLK_PERIOD);
		$display("Watchdog timeout, the tests did not finish in time");
		$display("tests failed");
		$finish;
	end

endmodule

// File: cpc_glue.f
logic/cpc_glue_pkg.sv
logic/rom_loader.sv
logic/mf2_control.sv
logic/mf2_shadow.sv
logic/cpc_glue.sv
verification/cpc_glue_checker.sv
verification/cpc_glue_tb.sv

// File: Makefile
# Verilator build for the CPC glue logic and its testbench

VERILATOR ?= verilator
TOP       ?= cpc_glue_tb
RTL_TOP   ?= cpc_glue
FILELIST  ?= cpc_glue.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= all tests passed
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/$(TOP): $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o $(TOP)

sim: $(BUILD_DIR)/$(TOP)
	-./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
